//--- core_types_pkg.sv
`default_nettype none

package core_types_pkg;

    // --------------------------------------------------
    // program counter and upct sizing
    // --------------------------------------------------

    // full fetch address width
    localparam int pc_width = 32;

    // upct holds eight upper regions, the plru tree depends on this
    localparam int upct_entries = 8;
    localparam int log_upct_entries = 3;

    typedef logic [log_upct_entries-1:0] upct_index_t;

    // --------------------------------------------------
    // front end request and response bundles
    // --------------------------------------------------

    // fetch pc to predict
    typedef struct packed {
        logic                valid;
        logic [pc_width-1:0] pc;
    } lookup_req_t;

    // answered one cycle after the request
    typedef struct packed {
        logic                valid;
        logic                hit;
        logic [pc_width-1:0] target_pc;
    } lookup_resp_t;

    // resolved branch from the back end
    typedef struct packed {
        logic                valid;
        logic [pc_width-1:0] src_pc;
        logic [pc_width-1:0] target_pc;
    } update_req_t;

endpackage

`default_nettype wire

//--- pq_lsb.sv
`timescale 1ns/1ns
`default_nettype none

module pq_lsb #(
    parameter int width = 8
) (
    input  wire logic [width-1:0]         req_vec,
    output logic      [$clog2(width)-1:0] ack_index
);

    localparam int index_width = $clog2(width);

    // --------------------------------------------------
    // lowest set bit wins
    // --------------------------------------------------

    // walk down from the top so the last write is the lowest set bit
    always_comb begin
        ack_index = '0;
        for (int i = width - 1; i >= 0; i--) begin
            if (req_vec[i]) begin
                ack_index = index_width'(i);
            end
        end
    end

    // no request leaves index zero, caller checks its own any-match

endmodule

`default_nettype wire

//--- upct.sv
`timescale 1ns/1ns
`default_nettype none

module upct #(
    parameter int upper_pc_width = 20
) (
    input  wire logic                                  CLK,
    input  wire logic                                  nRST,

    // resp stage read
    input  wire logic                                  valid_resp,
    input  wire core_types_pkg::upct_index_t           upct_index_resp,
    output logic [upper_pc_width-1:0]                  upper_pc_resp,

    // update0 request
    input  wire logic                                  update0_valid,
    input  wire logic [core_types_pkg::pc_width-1:0]   update0_target_pc,

    // update1 result
    output core_types_pkg::upct_index_t                update1_upct_index
);

    localparam int entries = core_types_pkg::upct_entries;

    // tree bits point toward the next victim
    typedef struct packed {
        logic            root;
        logic [1:0]      mid;
        logic [1:0][1:0] leaf;
    } plru_t;

    // --------------------------------------------------
    // state
    // --------------------------------------------------

    logic [entries-1:0][upper_pc_width-1:0] upct_array;
    logic [entries-1:0][upper_pc_width-1:0] next_upct_array;

    plru_t plru;
    plru_t next_plru;

    // update0
    logic [upper_pc_width-1:0] update0_upper_pc;
    logic [entries-1:0]        update0_match_vec;

    // update1
    logic                        update1_valid;
    logic [upper_pc_width-1:0]   update1_upper_pc;
    logic [entries-1:0]          update1_match_vec;
    logic                        update1_have_match;
    core_types_pkg::upct_index_t update1_match_index;
    core_types_pkg::upct_index_t plru_victim;

    // steer every tree level on the path away from idx
    function automatic plru_t point_away(plru_t cur, core_types_pkg::upct_index_t idx);
        plru_t nxt;
        nxt = cur;
        nxt.root = ~idx[2];
        nxt.mid[idx[2]] = ~idx[1];
        nxt.leaf[idx[2]][idx[1]] = ~idx[0];
        return nxt;
    endfunction

    // --------------------------------------------------
    // registers
    // --------------------------------------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            upct_array <= '0;
            plru <= '0;
            update1_valid <= 1'b0;
        end else begin
            upct_array <= next_upct_array;
            plru <= next_plru;
            update1_valid <= update0_valid;
        end
    end

    // qualified by update1_valid
    always_ff @(posedge CLK) begin
        update1_upper_pc <= update0_upper_pc;
        update1_match_vec <= update0_match_vec;
    end

    // --------------------------------------------------
    // update0 cam
    // --------------------------------------------------

    assign update0_upper_pc =
        update0_target_pc[core_types_pkg::pc_width-1 -: upper_pc_width];

    always_comb begin
        for (int i = 0; i < entries; i++) begin
            update0_match_vec[i] = (upct_array[i] == update0_upper_pc);
        end
    end

    // --------------------------------------------------
    // update1 select and plru
    // --------------------------------------------------

    assign update1_have_match = |update1_match_vec;

    pq_lsb #(
        .width(entries)
    ) cam_pq (
        .req_vec   (update1_match_vec),
        .ack_index (update1_match_index)
    );

    // follow the tree bits down to a leaf
    assign plru_victim = {plru.root, plru.mid[plru.root], plru.leaf[plru.root][plru.mid[plru.root]]};

    // resp read is a plain mux, no stage
    assign upper_pc_resp = upct_array[upct_index_resp];

    always_comb begin
        next_upct_array = upct_array;
        next_plru = plru;
        update1_upct_index = plru_victim;

        if (update1_valid && update1_have_match) begin
            // region already present, reuse it
            update1_upct_index = update1_match_index;
            next_plru = point_away(plru, update1_match_index);
        end else if (update1_valid) begin
            // new region takes the victim slot
            next_upct_array[plru_victim] = update1_upper_pc;
            // pointing away from the victim flips each bit on its path
            next_plru = point_away(plru, plru_victim);
        end else if (valid_resp) begin
            // lookup hit refresh, dropped when an update1 is in flight
            next_plru = point_away(plru, upct_index_resp);
        end
    end

endmodule

`default_nettype wire

//--- target_table.sv
`timescale 1ns/1ns
`default_nettype none

module target_table #(
    parameter int upper_pc_width = 20,
    parameter int tt_entries     = 64
) (
    input  wire logic                                  CLK,
    input  wire logic                                  nRST,

    // lookup in, resp stage out
    input  wire core_types_pkg::lookup_req_t           lookup_req,
    output logic                                       resp_valid,
    output logic                                       resp_hit,
    output logic [core_types_pkg::pc_width-upper_pc_width-1:0] resp_lower_target,
    output core_types_pkg::upct_index_t                resp_upct_index,

    // update0 in, update1 write
    input  wire core_types_pkg::update_req_t           update_req,
    input  wire core_types_pkg::upct_index_t           update1_upct_index
);

    localparam int pc_width    = core_types_pkg::pc_width;
    localparam int index_width = $clog2(tt_entries);
    // bits 1:0 are never part of index or tag
    localparam int tag_width   = pc_width - 2 - index_width;
    localparam int lower_width = pc_width - upper_pc_width;

    typedef struct packed {
        logic [tag_width-1:0]        tag;
        logic [lower_width-1:0]      lower_target;
        core_types_pkg::upct_index_t upct_index;
    } tt_entry_t;

    // --------------------------------------------------
    // storage
    // --------------------------------------------------

    logic [tt_entries-1:0] valid_array;
    tt_entry_t             entry_array [tt_entries];

    // lookup fields
    logic [index_width-1:0] lookup_index;
    logic [tag_width-1:0]   lookup_tag;
    tt_entry_t              lookup_entry;
    logic                   lookup_hit;

    // update0 fields
    logic [index_width-1:0] update0_index;
    logic [tag_width-1:0]   update0_tag;
    logic [lower_width-1:0] update0_lower_target;

    // update1 stage
    logic                   update1_valid;
    logic [index_width-1:0] update1_index;
    logic [tag_width-1:0]   update1_tag;
    logic [lower_width-1:0] update1_lower_target;

    // --------------------------------------------------
    // lookup read and tag compare
    // --------------------------------------------------

    assign lookup_index = lookup_req.pc[2 +: index_width];
    assign lookup_tag   = lookup_req.pc[pc_width-1 -: tag_width];
    assign lookup_entry = entry_array[lookup_index];

    assign lookup_hit = lookup_req.valid && valid_array[lookup_index]
        && (lookup_entry.tag == lookup_tag);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            resp_valid <= 1'b0;
            resp_hit <= 1'b0;
        end else begin
            resp_valid <= lookup_req.valid;
            resp_hit <= lookup_hit;
        end
    end

    // only meaningful with resp_hit
    always_ff @(posedge CLK) begin
        resp_lower_target <= lookup_entry.lower_target;
        resp_upct_index <= lookup_entry.upct_index;
    end

    // --------------------------------------------------
    // update pipeline
    // --------------------------------------------------

    assign update0_index        = update_req.src_pc[2 +: index_width];
    assign update0_tag          = update_req.src_pc[pc_width-1 -: tag_width];
    assign update0_lower_target = update_req.target_pc[lower_width-1:0];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            update1_valid <= 1'b0;
            valid_array <= '0;
        end else begin
            update1_valid <= update_req.valid;
            if (update1_valid) begin
                valid_array[update1_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        update1_index <= update0_index;
        update1_tag <= update0_tag;
        update1_lower_target <= update0_lower_target;
    end

    // upct index arrives combinationally in update1
    always_ff @(posedge CLK) begin
        if (update1_valid) begin
            entry_array[update1_index] <= '{
                tag:          update1_tag,
                lower_target: update1_lower_target,
                upct_index:   update1_upct_index
            };
        end
    end

endmodule

`default_nettype wire

//--- target_predictor.sv
`timescale 1ns/1ns
`default_nettype none

module target_predictor #(
    parameter int upper_pc_width = 20,
    parameter int tt_entries     = 64
) (
    input  wire logic                         CLK,
    input  wire logic                         nRST,

    input  wire core_types_pkg::lookup_req_t  lookup_req,
    input  wire core_types_pkg::update_req_t  update_req,
    output core_types_pkg::lookup_resp_t      lookup_resp
);

    localparam int lower_width = core_types_pkg::pc_width - upper_pc_width;

    // --------------------------------------------------
    // resp stage and update1 wiring
    // --------------------------------------------------

    logic                        tt_resp_valid;
    logic                        tt_resp_hit;
    logic [lower_width-1:0]      tt_resp_lower_target;
    core_types_pkg::upct_index_t tt_resp_upct_index;

    logic [upper_pc_width-1:0]   upper_pc_resp;
    core_types_pkg::upct_index_t update1_upct_index;

    target_table #(
        .upper_pc_width (upper_pc_width),
        .tt_entries     (tt_entries)
    ) tt (
        .CLK                (CLK),
        .nRST               (nRST),
        .lookup_req         (lookup_req),
        .resp_valid         (tt_resp_valid),
        .resp_hit           (tt_resp_hit),
        .resp_lower_target  (tt_resp_lower_target),
        .resp_upct_index    (tt_resp_upct_index),
        .update_req         (update_req),
        .update1_upct_index (update1_upct_index)
    );

    // only a real hit touches the plru
    upct #(
        .upper_pc_width (upper_pc_width)
    ) upc_table (
        .CLK                (CLK),
        .nRST               (nRST),
        .valid_resp         (tt_resp_valid & tt_resp_hit),
        .upct_index_resp    (tt_resp_upct_index),
        .upper_pc_resp      (upper_pc_resp),
        .update0_valid      (update_req.valid),
        .update0_target_pc  (update_req.target_pc),
        .update1_upct_index (update1_upct_index)
    );

    // --------------------------------------------------
    // response assembly
    // --------------------------------------------------

    always_comb begin
        lookup_resp.valid = tt_resp_valid;
        lookup_resp.hit = tt_resp_hit;
        // target is zero on a miss
        if (tt_resp_hit) begin
            lookup_resp.target_pc = {upper_pc_resp, tt_resp_lower_target};
        end else begin
            lookup_resp.target_pc = '0;
        end
    end

endmodule

`default_nettype wire

//--- target_predictor_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module target_predictor_assertions (
    input wire logic                         CLK,
    input wire logic                         nRST,
    input wire core_types_pkg::lookup_req_t  lookup_req,
    input wire core_types_pkg::lookup_resp_t lookup_resp
);

    // --------------------------------------------------
    // port protocol
    // --------------------------------------------------

    // fixed one cycle lookup latency
    resp_after_req: assert property (@(posedge CLK) disable iff (!nRST)
        lookup_req.valid |=> lookup_resp.valid)
        else $error("no lookup response one cycle after a lookup request");

    no_resp_without_req: assert property (@(posedge CLK) disable iff (!nRST)
        !lookup_req.valid |=> !lookup_resp.valid)
        else $error("lookup response without a request in the cycle before");

    hit_needs_valid: assert property (@(posedge CLK) disable iff (!nRST)
        lookup_resp.hit |-> lookup_resp.valid)
        else $error("lookup hit reported without a valid response");

    quiet_in_reset: assert property (@(posedge CLK) !nRST |-> !lookup_resp.valid)
        else $error("lookup response valid while in reset");

endmodule

bind target_predictor target_predictor_assertions port_checks (
    .CLK         (CLK),
    .nRST        (nRST),
    .lookup_req  (lookup_req),
    .lookup_resp (lookup_resp)
);

`default_nettype wire

//--- tb_target_predictor.sv
`timescale 1ns/1ns
`default_nettype none

module tb_target_predictor;

    localparam int pc_width       = core_types_pkg::pc_width;
    localparam int upper_pc_width = 20;
    localparam int tt_entries     = 64;
    localparam int index_width    = $clog2(tt_entries);
    localparam int tag_width      = pc_width - 2 - index_width;
    localparam int lower_width    = pc_width - upper_pc_width;
    localparam int random_cycles  = 2000;
    // about 2100 cycles of tests in total
    localparam int max_cycles     = 3000;

    logic                         CLK;
    logic                         nRST;
    core_types_pkg::lookup_req_t  lookup_req;
    core_types_pkg::update_req_t  update_req;
    core_types_pkg::lookup_resp_t lookup_resp;

    integer              seed;
    int                  cycle_count = 0;
    int                  region_sel;
    logic [31:0]         rnd;
    logic [31:0]         rnd_low;
    logic [pc_width-1:0] lk_pc;
    logic [pc_width-1:0] up_tgt;
    logic [pc_width-1:0] exp_target;
    logic [pc_width-1:0] pool_pc [16];

    // --------------------------------------------------
    // reference model state
    // --------------------------------------------------

    logic                      m_valid [tt_entries];
    logic [tag_width-1:0]      m_tag   [tt_entries];
    logic [lower_width-1:0]    m_lower [tt_entries];
    logic [2:0]                m_index [tt_entries];
    logic [upper_pc_width-1:0] m_upct  [8];
    logic                      m_root;
    logic [1:0]                m_mid;
    logic [3:0]                m_leaf;
    logic                      m_resp_valid;
    logic                      m_resp_hit;
    logic [lower_width-1:0]    m_resp_lower;
    logic [2:0]                m_resp_index;
    logic                      m_u1_valid;
    logic [pc_width-1:0]       m_u1_src;
    logic [pc_width-1:0]       m_u1_target;
    logic [7:0]                m_u1_match;

    target_predictor uut (
        .CLK         (CLK),
        .nRST        (nRST),
        .lookup_req  (lookup_req),
        .update_req  (update_req),
        .lookup_resp (lookup_resp)
    );

    always #2 CLK = ~CLK;

    function automatic logic [index_width-1:0] index_of(input logic [pc_width-1:0] pc);
        return pc[2 +: index_width];
    endfunction

    function automatic logic [tag_width-1:0] tag_of(input logic [pc_width-1:0] pc);
        return pc[pc_width-1 -: tag_width];
    endfunction

    function automatic logic [upper_pc_width-1:0] upper_of(input logic [pc_width-1:0] pc);
        return pc[pc_width-1 -: upper_pc_width];
    endfunction

    function automatic logic [2:0] lowest_set(input logic [7:0] vec);
        for (int i = 0; i < 8; i++) begin
            if (vec[i]) begin
                return 3'(i);
            end
        end
        return 3'd0;
    endfunction

    // tree walk toward the next victim
    function automatic logic [2:0] plru_victim();
        logic [2:0] v;
        v[2] = m_root;
        v[1] = m_mid[v[2]];
        v[0] = m_leaf[v[2:1]];
        return v;
    endfunction

    task automatic plru_point_away(input logic [2:0] idx);
        m_root = ~idx[2];
        m_mid[idx[2]] = ~idx[1];
        m_leaf[idx[2:1]] = ~idx[0];
    endtask

    task automatic model_reset();
        for (int i = 0; i < tt_entries; i++) begin
            m_valid[i] = 1'b0;
        end
        for (int i = 0; i < 8; i++) begin
            m_upct[i] = '0;
        end
        m_root = 1'b0;
        m_mid = '0;
        m_leaf = '0;
        m_resp_valid = 1'b0;
        m_resp_hit = 1'b0;
        m_resp_lower = '0;
        m_resp_index = '0;
        m_u1_valid = 1'b0;
        m_u1_src = '0;
        m_u1_target = '0;
        m_u1_match = '0;
    endtask

    task automatic model_step();
        logic [7:0]             match;
        logic [2:0]             sel;
        logic [index_width-1:0] li;
        logic [index_width-1:0] ui;
        logic                   look_hit;
        logic [lower_width-1:0] look_lower;
        logic [2:0]             look_index;

        // cam and table read see the state before this edge
        for (int i = 0; i < 8; i++) begin
            match[i] = (m_upct[i] == upper_of(update_req.target_pc));
        end
        li = index_of(lookup_req.pc);
        look_hit = lookup_req.valid && m_valid[li] && (m_tag[li] == tag_of(lookup_req.pc));
        look_lower = m_lower[li];
        look_index = m_index[li];

        sel = plru_victim();
        if (m_u1_valid && (m_u1_match != 8'h00)) begin
            sel = lowest_set(m_u1_match);
            plru_point_away(sel);
        end else if (m_u1_valid) begin
            m_upct[sel] = upper_of(m_u1_target);
            plru_point_away(sel);
        end else if (m_resp_valid && m_resp_hit) begin
            plru_point_away(m_resp_index);
        end

        if (m_u1_valid) begin
            ui = index_of(m_u1_src);
            m_valid[ui] = 1'b1;
            m_tag[ui] = tag_of(m_u1_src);
            m_lower[ui] = m_u1_target[lower_width-1:0];
            m_index[ui] = sel;
        end

        m_resp_valid = lookup_req.valid;
        m_resp_hit = look_hit;
        m_resp_lower = look_lower;
        m_resp_index = look_index;
        m_u1_valid = update_req.valid;
        m_u1_src = update_req.src_pc;
        m_u1_target = update_req.target_pc;
        m_u1_match = match;
    endtask

    task automatic report_failure();
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [pc_width-1:0] got,
                               input logic [pc_width-1:0] exp);
        assert (got === exp) else begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            report_failure();
        end
    endtask

    // --------------------------------------------------
    // model, checks and cycle limit
    // --------------------------------------------------

    always @(posedge CLK) begin
        if (!nRST) begin
            model_reset();
        end else begin
            model_step();
        end
    end

    always @(negedge CLK) begin
        if (m_resp_hit) begin
            exp_target = {m_upct[m_resp_index], m_resp_lower};
        end else begin
            exp_target = '0;
        end
        check_value("lookup_resp.valid", pc_width'(lookup_resp.valid), pc_width'(m_resp_valid));
        check_value("lookup_resp.hit", pc_width'(lookup_resp.hit), pc_width'(m_resp_hit));
        check_value("lookup_resp.target_pc", lookup_resp.target_pc, exp_target);
    end

    always @(posedge CLK) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > max_cycles) begin
            $display("timeout, the tests did not finish within %0d cycles", max_cycles);
            report_failure();
        end
    end

    task automatic drive_cycle(input logic lk_valid, input logic [pc_width-1:0] pc,
                               input logic up_valid, input logic [pc_width-1:0] src,
                               input logic [pc_width-1:0] tgt);
        @(posedge CLK);
        lookup_req <= '{valid: lk_valid, pc: pc};
        update_req <= '{valid: up_valid, src_pc: src, target_pc: tgt};
    endtask

    task automatic idle(input int n);
        repeat (n) drive_cycle(1'b0, '0, 1'b0, '0, '0);
    endtask

    task automatic update_branch(input logic [pc_width-1:0] src, input logic [pc_width-1:0] tgt);
        drive_cycle(1'b0, '0, 1'b1, src, tgt);
    endtask

    task automatic lookup_branch(input logic [pc_width-1:0] pc);
        drive_cycle(1'b1, pc, 1'b0, '0, '0);
    endtask

    // direct check against the expected target
    task automatic expect_lookup(input logic [pc_width-1:0] pc, input logic hit,
                                 input logic [pc_width-1:0] tgt);
        lookup_branch(pc);
        idle(1);
        @(negedge CLK);
        check_value("lookup_resp.hit", pc_width'(lookup_resp.hit), pc_width'(hit));
        check_value("lookup_resp.target_pc", lookup_resp.target_pc, tgt);
    endtask

    initial begin
        seed = 44;
        CLK = 1'b0;
        nRST = 1'b0;
        lookup_req = '0;
        update_req = '0;
        // three tags over four indexes so entries alias
        for (int i = 0; i < 16; i++) begin
            pool_pc[i] = {24'h000010 + 24'(i % 3), 6'(i % 4), 2'b00};
        end
        repeat (16) @(posedge CLK);
        nRST <= 1'b1;

        // empty table
        for (int i = 0; i < 8; i++) begin
            expect_lookup(32'h0000_4000 + 32'(i * 'h44), 1'b0, '0);
        end

        // write then read back with the old entry one cycle later
        update_branch(32'h0000_1000, 32'h0004_5678);
        expect_lookup(32'h0000_1000, 1'b0, '0);
        expect_lookup(32'h0000_1000, 1'b1, 32'h0004_5678);
        update_branch(32'h0000_1000, 32'h0004_5abc);
        expect_lookup(32'h0000_1000, 1'b1, 32'h0004_5678);
        expect_lookup(32'h0000_1000, 1'b1, 32'h0004_5abc);

        // shared upper region
        update_branch(32'h0000_1004, 32'h0004_51f0);
        update_branch(32'h0000_1008, 32'h0004_50a4);
        update_branch(32'h0000_100c, 32'h0004_5ffc);
        update_branch(32'h0000_1010, 32'h0012_3400);
        idle(1);
        expect_lookup(32'h0000_1000, 1'b1, 32'h0004_5abc);
        expect_lookup(32'h0000_1004, 1'b1, 32'h0004_51f0);
        expect_lookup(32'h0000_1008, 1'b1, 32'h0004_50a4);
        expect_lookup(32'h0000_100c, 1'b1, 32'h0004_5ffc);
        expect_lookup(32'h0000_1010, 1'b1, 32'h0012_3400);

        // ten new regions force evictions
        for (int k = 0; k < 10; k++) begin
            update_branch(32'h0008_0040 + 32'(k * 4), {20'h20000 + 20'(k), 12'h300 + 12'(k)});
        end
        idle(2);
        for (int k = 0; k < 10; k++) begin
            lookup_branch(32'h0008_0040 + 32'(k * 4));
        end
        for (int k = 0; k < 5; k++) begin
            lookup_branch(32'h0000_1000 + 32'(k * 4));
        end

        // lookup hits whose resp stage meets an update1
        for (int k = 0; k < 6; k++) begin
            drive_cycle(1'b1, 32'h0008_0040 + 32'(k * 4), 1'b1,
                        32'h0008_0100 + 32'(k * 4), {20'h30000 + 20'(k), 12'h5a0});
        end
        idle(2);
        for (int k = 0; k < 10; k++) begin
            lookup_branch(32'h0008_0040 + 32'(k * 4));
            lookup_branch(32'h0008_0100 + 32'(k * 4));
        end

        // random mix over the pool and twelve regions
        for (int c = 0; c < random_cycles; c++) begin
            rnd = $random(seed);
            rnd_low = $random(seed);
            region_sel = int'(rnd[19:16]) % 12;
            lk_pc = (rnd[7:5] == 3'b000) ? rnd_low : pool_pc[rnd[11:8]];
            up_tgt = {20'(region_sel * 'h1235), rnd_low[lower_width-1:0]};
            drive_cycle(rnd[1:0] != 2'b00, lk_pc, rnd[3:2] == 2'b00, pool_pc[rnd[15:12]], up_tgt);
        end
        idle(4);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
core_types_pkg.sv
pq_lsb.sv
upct.sv
target_table.sv
target_predictor.sv
target_predictor_assertions.sv
tb_target_predictor.sv

//--- run_sim.sh
#!/bin/sh
# build and run the target predictor testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f build.f \
    --top-module tb_target_predictor \
    -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_tb 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Simulation PASSED"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
